/* common/cpu_config.svh */
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// ##############################
// Processor sizes.
// ##############################

// Program counter and instruction memory address width.
`define PC_W 8

// Data memory address width, taken from the low bits of a register.
`define DADDR_W 8

// Number of general purpose registers.
`define NUM_REGS 32

`endif

/* common/cpu_pkg.sv */
`include "cpu_config.svh"

package cpu_pkg;

   typedef logic [31:0]          word_t;
   typedef logic [31:0]          instr_t;
   typedef logic [4:0]           reg_idx_t;
   typedef logic [`PC_W-1:0]     pc_t;
   typedef logic [`DADDR_W-1:0]  daddr_t;

   // ##############################
   // Instruction encoding.
   //   opcode       31..29
   //   rd           28..24  destination.
   //   ra           23..19  first source.
   //   rb           18..14  second source.
   //   ALU function  1..0
   //   immediate    15..0   zero-extended.
   //   jump target   7..0
   // Load reads the address from ra, store writes ra to the address in rb.
   // ##############################

   typedef enum logic [2:0] {
      NOP      = 3'd0,
      LOAD_IMM = 3'd1,
      LOAD     = 3'd2,
      STORE    = 3'd3,
      JUMP     = 3'd4,
      ALU_OP   = 3'd5    // 6 and 7 run as no-ops.
   } opcode_e;

   typedef enum logic [2:0] {
      FETCH      = 3'd0,
      MEM_READ   = 3'd1,
      REG_UPDATE = 3'd2,
      MEM_WRITE  = 3'd3,
      PC_UPDATE  = 3'd4
   } stage_e;

   typedef enum logic [1:0] {
      ADD = 2'd0,
      SUB = 2'd1,
      AND = 2'd2,
      XOR = 2'd3
   } alu_func_e;

endpackage

/* rtl/alu.sv */
`timescale 1ns/100ps

module alu (
   input  cpu_pkg::word_t       a_i,
   input  cpu_pkg::word_t       b_i,
   input  cpu_pkg::alu_func_e   func_i,
   output cpu_pkg::word_t       result_o
);

   import cpu_pkg::*;

   always_comb begin
      result_o = '0;
      case (func_i)
         ADD: result_o = a_i + b_i;
         SUB: result_o = a_i - b_i;   // Wraps modulo 2**32.
         AND: result_o = a_i & b_i;
         XOR: result_o = a_i ^ b_i;
         default: result_o = '0;
      endcase
   end

endmodule

/* rtl/regfile/register_file.sv */
`timescale 1ns/100ps
`include "cpu_config.svh"

module register_file (
   input  logic                clk_i,
   input  logic                arst_n_i,
   input  cpu_pkg::reg_idx_t   read_idx_0_i,
   input  cpu_pkg::reg_idx_t   read_idx_1_i,
   input  cpu_pkg::reg_idx_t   write_idx_i,
   input  cpu_pkg::word_t      write_data_i,
   input  logic                write_en_i,
   output cpu_pkg::word_t      rdata_0_o,
   output cpu_pkg::word_t      rdata_1_o
);

   import cpu_pkg::*;

   word_t regs_q [`NUM_REGS];

   // ##############################
   // Storage.
   // ##############################

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         for (int i = 0; i < `NUM_REGS; i++) begin
            regs_q[i] <= '0;
         end
      end else if (write_en_i) begin
         regs_q[write_idx_i] <= write_data_i;
      end
   end

   // Reads see the old value during a write cycle.
   assign rdata_0_o = regs_q[read_idx_0_i];
   assign rdata_1_o = regs_q[read_idx_1_i];

endmodule

/* rtl/regfile/register_file_control.sv */
`timescale 1ns/100ps

module register_file_control (
   input  cpu_pkg::stage_e     stage_i,
   input  cpu_pkg::opcode_e    opcode_i,
   input  cpu_pkg::reg_idx_t   rd_i,
   input  cpu_pkg::reg_idx_t   ra_i,
   input  cpu_pkg::reg_idx_t   rb_i,
   input  cpu_pkg::word_t      imm_i,
   input  cpu_pkg::word_t      load_data_i,
   input  cpu_pkg::word_t      alu_result_i,
   output cpu_pkg::reg_idx_t   read_idx_0_o,
   output cpu_pkg::reg_idx_t   read_idx_1_o,
   output cpu_pkg::reg_idx_t   write_idx_o,
   output cpu_pkg::word_t      write_data_o,
   output logic                write_en_o
);

   import cpu_pkg::*;

   logic writes_reg;

   // ##############################
   // Read and write selection.
   // ##############################

   always_comb begin
      read_idx_0_o = '0;
      read_idx_1_o = '0;
      write_idx_o  = '0;
      write_data_o = '0;
      writes_reg   = 1'b0;

      case (opcode_i)
         LOAD_IMM: begin
            write_idx_o  = rd_i;
            write_data_o = imm_i;
            writes_reg   = 1'b1;
         end
         LOAD: begin
            read_idx_0_o = ra_i;   // Address register.
            write_idx_o  = rd_i;
            write_data_o = load_data_i;
            writes_reg   = 1'b1;
         end
         ALU_OP: begin
            read_idx_0_o = ra_i;
            read_idx_1_o = rb_i;
            write_idx_o  = rd_i;
            write_data_o = alu_result_i;
            writes_reg   = 1'b1;
         end
         STORE: begin
            read_idx_0_o = ra_i;   // Data.
            read_idx_1_o = rb_i;   // Address.
         end
         default: begin
            writes_reg = 1'b0;
         end
      endcase
   end

   // Register writes happen only in the update stage.
   assign write_en_o = (stage_i == REG_UPDATE) && writes_reg;

endmodule

/* rtl/stage_sequencer.sv */
`timescale 1ns/100ps
`include "cpu_config.svh"

module stage_sequencer (
   input  logic                 clk_i,
   input  logic                 arst_n_i,
   input  cpu_pkg::instr_t      imem_data_i,
   input  cpu_pkg::word_t       dmem_rdata_i,
   input  cpu_pkg::word_t       rdata_0_i,
   input  cpu_pkg::word_t       rdata_1_i,
   output cpu_pkg::stage_e      stage_o,
   output cpu_pkg::opcode_e     opcode_o,
   output cpu_pkg::reg_idx_t    rd_o,
   output cpu_pkg::reg_idx_t    ra_o,
   output cpu_pkg::reg_idx_t    rb_o,
   output cpu_pkg::word_t       imm_o,
   output cpu_pkg::alu_func_e   alu_func_o,
   output cpu_pkg::word_t       load_data_o,
   output cpu_pkg::pc_t         imem_addr_o,
   output cpu_pkg::daddr_t      dmem_addr_o,
   output cpu_pkg::word_t       dmem_wdata_o,
   output logic                 dmem_we_o
);

   import cpu_pkg::*;

   stage_e stage_q;
   stage_e stage_d;
   pc_t    pc_q;
   instr_t instr_q;
   word_t  load_data_q;
   logic   is_load;
   logic   is_store;
   logic   is_jump;
   pc_t    jump_target;

   // ##############################
   // Stage FSM.
   // ##############################

   always_comb begin
      case (stage_q)
         FETCH:      stage_d = MEM_READ;
         MEM_READ:   stage_d = REG_UPDATE;
         REG_UPDATE: stage_d = MEM_WRITE;
         MEM_WRITE:  stage_d = PC_UPDATE;
         default:    stage_d = FETCH;   // PC_UPDATE wraps around.
      endcase
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         stage_q <= FETCH;
         pc_q    <= '0;
         instr_q <= '0;   // Opcode zero is a no-op.
      end else begin
         stage_q <= stage_d;
         if (stage_q == FETCH) begin
            instr_q <= imem_data_i;
         end
         if (stage_q == PC_UPDATE) begin
            pc_q <= is_jump ? jump_target : pc_q + pc_t'(1);
         end
      end
   end

   // Word returned by a load, written back in the next stage.
   always_ff @(posedge clk_i) begin
      if (stage_q == MEM_READ && is_load) begin
         load_data_q <= dmem_rdata_i;
      end
   end

   // ##############################
   // Field decode.
   // ##############################

   assign opcode_o    = opcode_e'(instr_q[31:29]);
   assign rd_o        = instr_q[28:24];
   assign ra_o        = instr_q[23:19];
   assign rb_o        = instr_q[18:14];
   assign imm_o       = {16'h0000, instr_q[15:0]};
   assign alu_func_o  = alu_func_e'(instr_q[1:0]);
   assign jump_target = instr_q[`PC_W-1:0];

   assign is_load  = (opcode_o == LOAD);
   assign is_store = (opcode_o == STORE);
   assign is_jump  = (opcode_o == JUMP);

   assign stage_o     = stage_q;
   assign load_data_o = load_data_q;
   assign imem_addr_o = pc_q;

   // ##############################
   // Data memory port.
   // ##############################

   always_comb begin
      dmem_addr_o = '0;
      case (stage_q)
         MEM_READ:  dmem_addr_o = rdata_0_i[`DADDR_W-1:0];   // Load address in ra.
         MEM_WRITE: dmem_addr_o = rdata_1_i[`DADDR_W-1:0];   // Store address in rb.
         default:   dmem_addr_o = '0;
      endcase
   end

   // One strobe per store, no back-pressure.
   assign dmem_we_o    = (stage_q == MEM_WRITE) && is_store;
   assign dmem_wdata_o = dmem_we_o ? rdata_0_i : '0;

endmodule

/* rtl/cpu_top.sv */
`timescale 1ns/100ps

module cpu_top (
   input  logic              clk_i,
   input  logic              arst_n_i,
   // Instruction memory.
   output cpu_pkg::pc_t      imem_addr_o,
   input  cpu_pkg::instr_t   imem_data_i,
   // Data memory.
   output cpu_pkg::daddr_t   dmem_addr_o,
   input  cpu_pkg::word_t    dmem_rdata_i,
   output cpu_pkg::word_t    dmem_wdata_o,
   output logic              dmem_we_o
);

   import cpu_pkg::*;

   stage_e    stage;
   opcode_e   opcode;
   reg_idx_t  rd;
   reg_idx_t  ra;
   reg_idx_t  rb;
   word_t     imm;
   alu_func_e alu_func;
   word_t     load_data;

   reg_idx_t  read_idx_0;
   reg_idx_t  read_idx_1;
   reg_idx_t  write_idx;
   word_t     write_data;
   logic      write_en;

   word_t     rdata_0;
   word_t     rdata_1;
   word_t     alu_result;

   stage_sequencer i_sequencer (
      .clk_i        (clk_i),
      .arst_n_i     (arst_n_i),
      .imem_data_i  (imem_data_i),
      .dmem_rdata_i (dmem_rdata_i),
      .rdata_0_i    (rdata_0),
      .rdata_1_i    (rdata_1),
      .stage_o      (stage),
      .opcode_o     (opcode),
      .rd_o         (rd),
      .ra_o         (ra),
      .rb_o         (rb),
      .imm_o        (imm),
      .alu_func_o   (alu_func),
      .load_data_o  (load_data),
      .imem_addr_o  (imem_addr_o),
      .dmem_addr_o  (dmem_addr_o),
      .dmem_wdata_o (dmem_wdata_o),
      .dmem_we_o    (dmem_we_o)
   );

   register_file_control i_rf_ctrl (
      .stage_i      (stage),
      .opcode_i     (opcode),
      .rd_i         (rd),
      .ra_i         (ra),
      .rb_i         (rb),
      .imm_i        (imm),
      .load_data_i  (load_data),
      .alu_result_i (alu_result),
      .read_idx_0_o (read_idx_0),
      .read_idx_1_o (read_idx_1),
      .write_idx_o  (write_idx),
      .write_data_o (write_data),
      .write_en_o   (write_en)
   );

   register_file i_rf (
      .clk_i        (clk_i),
      .arst_n_i     (arst_n_i),
      .read_idx_0_i (read_idx_0),
      .read_idx_1_i (read_idx_1),
      .write_idx_i  (write_idx),
      .write_data_i (write_data),
      .write_en_i   (write_en),
      .rdata_0_o    (rdata_0),
      .rdata_1_o    (rdata_1)
   );

   alu i_alu (
      .a_i      (rdata_0),
      .b_i      (rdata_1),
      .func_i   (alu_func),
      .result_o (alu_result)
   );

endmodule

/* bench/tb_memory_model.sv */
`timescale 1ns/100ps

module tb_memory_model (
   input  logic              clk_i,
   input  logic              arst_n_i,
   input  cpu_pkg::pc_t      imem_addr_i,
   output cpu_pkg::instr_t   imem_data_o,
   input  cpu_pkg::daddr_t   dmem_addr_i,
   output cpu_pkg::word_t    dmem_rdata_o,
   input  cpu_pkg::word_t    dmem_wdata_i,
   input  logic              dmem_we_i
);

   import cpu_pkg::*;

   localparam int LOG_DEPTH = 16;

   instr_t imem [256];
   word_t  dmem [256];

   // Store log, in strobe order.
   int     log_count;
   int     log_cycle [LOG_DEPTH];
   daddr_t log_addr  [LOG_DEPTH];
   word_t  log_data  [LOG_DEPTH];
   logic   strobe_in_reset;
   int     cycle;

   assign imem_data_o  = imem[imem_addr_i];
   assign dmem_rdata_o = dmem[dmem_addr_i];

   always @(posedge clk_i) begin
      if (dmem_we_i) begin
         dmem[dmem_addr_i] <= dmem_wdata_i;
      end
   end

   // Cycle 0 is the cycle after reset release.
   always @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         cycle <= 0;
      end else begin
         cycle <= cycle + 1;
      end
   end

   // Strobes are sampled mid-cycle.
   always @(negedge clk_i) begin
      if (!arst_n_i) begin
         if (dmem_we_i) strobe_in_reset = 1'b1;
      end else if (dmem_we_i) begin
         if (log_count < LOG_DEPTH) begin
            log_cycle[log_count] = cycle;
            log_addr[log_count]  = dmem_addr_i;
            log_data[log_count]  = dmem_wdata_i;
         end
         log_count = log_count + 1;
      end
   end

   // ##############################
   // Access for the testbench.
   // ##############################

   task automatic fill_memories();
      logic [7:0] a;
      for (int i = 0; i < 256; i++) begin
         a       = i;
         imem[i] = {JUMP, 21'h0, a};   // A runaway PC lands on a self jump.
         dmem[i] = {16'hDA7A, ~a, a};
      end
   endtask

   task automatic write_instr(int addr, instr_t word);
      imem[addr] = word;
   endtask

   task automatic write_data(int addr, word_t word);
      dmem[addr] = word;
   endtask

   task automatic clear_log();
      log_count       = 0;
      strobe_in_reset = 1'b0;
   endtask

endmodule

/* bench/tb_cpu.sv */
`timescale 1ns/100ps

module tb_cpu;

   import cpu_pkg::*;

   // Instructions executed per test.
   localparam int N_LI_STORE  = 4;
   localparam int N_ALU       = 15;
   localparam int N_LOAD      = 5;
   localparam int N_JUMP      = 5;
   localparam int N_RANDOM    = 9;
   localparam int RANDOM_RUNS = 3;
   localparam int N_NOP       = 7;
   localparam int CYCLE_LIMIT = (N_LI_STORE + N_ALU + N_LOAD + N_JUMP
                                 + N_RANDOM * RANDOM_RUNS + N_NOP) * 5 + 100;

   logic   clk;
   logic   arst_n;
   pc_t    imem_addr;
   instr_t imem_data;
   daddr_t dmem_addr;
   word_t  dmem_rdata;
   word_t  dmem_wdata;
   logic   dmem_we;

   int     cycle_count;
   int     test_errors;
   int     pass_count;
   int     fail_count;
   int     prog_len;
   integer seed;
   string  test_name;

   cpu_top i_dut (
      .clk_i        (clk),
      .arst_n_i     (arst_n),
      .imem_addr_o  (imem_addr),
      .imem_data_i  (imem_data),
      .dmem_addr_o  (dmem_addr),
      .dmem_rdata_i (dmem_rdata),
      .dmem_wdata_o (dmem_wdata),
      .dmem_we_o    (dmem_we)
   );

   tb_memory_model i_mem (
      .clk_i        (clk),
      .arst_n_i     (arst_n),
      .imem_addr_i  (imem_addr),
      .imem_data_o  (imem_data),
      .dmem_addr_i  (dmem_addr),
      .dmem_rdata_o (dmem_rdata),
      .dmem_wdata_i (dmem_wdata),
      .dmem_we_i    (dmem_we)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   always @(posedge clk) begin
      cycle_count = cycle_count + 1;
      if (cycle_count >= CYCLE_LIMIT) begin
         $display("Timeout: the run did not end within %0d clock cycles.", CYCLE_LIMIT);
         $display("SOME TESTS FAILED");
         $finish;
      end
   end

   // ##############################
   // Instruction encoding.
   // ##############################

   function automatic instr_t enc_li(reg_idx_t rd, logic [15:0] imm);
      return {LOAD_IMM, rd, 8'h00, imm};
   endfunction

   function automatic instr_t enc_load(reg_idx_t rd, reg_idx_t ra);
      return {LOAD, rd, ra, 19'h0};
   endfunction

   function automatic instr_t enc_store(reg_idx_t ra, reg_idx_t rb);
      return {STORE, 5'h00, ra, rb, 14'h0};   // Data in ra, address in rb.
   endfunction

   function automatic instr_t enc_jump(pc_t target);
      return {JUMP, 21'h0, target};
   endfunction

   function automatic instr_t enc_alu(reg_idx_t rd, reg_idx_t ra, reg_idx_t rb, alu_func_e f);
      return {ALU_OP, rd, ra, rb, 12'h0, f};
   endfunction

   function automatic instr_t enc_raw(logic [2:0] op, reg_idx_t rd, logic [15:0] imm);
      return {op, rd, 8'h00, imm};
   endfunction

   task automatic emit(instr_t word);
      i_mem.write_instr(prog_len, word);
      prog_len = prog_len + 1;
   endtask

   task automatic emit_self_jump();
      emit(enc_jump(pc_t'(prog_len)));
   endtask

   // ##############################
   // Sequencing and checks.
   // ##############################

   task automatic start_test(string name);
      test_name   = name;
      test_errors = 0;
   endtask

   task automatic load_start();
      @(posedge clk);
      #10;
      arst_n   = 1'b0;
      prog_len = 0;
      i_mem.clear_log();
      i_mem.fill_memories();
   endtask

   task automatic run_program(int n_instr);
      repeat (4) @(posedge clk);
      #10;
      arst_n = 1'b1;
      repeat (5 * n_instr) @(posedge clk);   // Five stages per instruction.
      #10;
      if (i_mem.strobe_in_reset) begin
         $display("Test %s: a data memory write strobe came during reset.", test_name);
         test_errors++;
      end
   endtask

   task automatic finish_test();
      if (test_errors == 0) begin
         pass_count++;
         $display("PASS  %s", test_name);
      end else begin
         fail_count++;
         $display("FAIL  %s (%0d errors)", test_name, test_errors);
      end
   endtask

   task automatic compare_word(string what, word_t got, word_t exp);
      if (got !== exp) begin
         $display("** Error at %0d ns: %s, %s is %h, expected %h",
                  $time, test_name, what, got, exp);
         test_errors++;
      end
   endtask

   task automatic compare_daddr(string what, daddr_t got, daddr_t exp);
      if (got !== exp) begin
         $display("** Error at %0d ns: %s, %s is %h, expected %h",
                  $time, test_name, what, got, exp);
         test_errors++;
      end
   endtask

   task automatic compare_pc(string what, pc_t got, pc_t exp);
      if (got !== exp) begin
         $display("** Error at %0d ns: %s, %s is %h, expected %h",
                  $time, test_name, what, got, exp);
         test_errors++;
      end
   endtask

   task automatic compare_count(string what, int got, int exp);
      if (got != exp) begin
         $display("** Error at %0d ns: %s, %s is %0d, expected %0d",
                  $time, test_name, what, got, exp);
         test_errors++;
      end
   endtask

   task automatic compare_cycle(string what, int got, int exp);
      if (got != exp) begin
         $display("** Error at %0d ns: %s, %s is cycle %0d, expected cycle %0d",
                  $time, test_name, what, got, exp);
         test_errors++;
      end
   endtask

   task automatic check_store(int idx, daddr_t exp_addr, word_t exp_data);
      if (idx >= i_mem.log_count) begin
         $display("Test %s: store %0d never produced a write strobe.", test_name, idx);
         test_errors++;
      end else begin
         compare_daddr($sformatf("store %0d address", idx), i_mem.log_addr[idx], exp_addr);
         compare_word($sformatf("store %0d data", idx), i_mem.log_data[idx], exp_data);
      end
   endtask

   // ##############################
   // Directed tests.
   // ##############################

   task automatic test_li_store();
      start_test("load immediate then store");
      load_start();
      emit(enc_li(5'd3, 16'h1234));
      emit(enc_li(5'd4, 16'h0007));
      emit(enc_store(5'd3, 5'd4));
      emit_self_jump();
      run_program(N_LI_STORE);
      compare_count("store count", i_mem.log_count, 1);
      check_store(0, 8'h07, 32'h0000_1234);
      if (i_mem.log_count > 0) begin
         compare_cycle("store", i_mem.log_cycle[0], 5 * 2 + 3);   // Instruction 2, MEM_WRITE.
      end
      finish_test();
   endtask

   task automatic test_alu_funcs();
      alu_func_e funcs [4] = '{ADD, SUB, AND, XOR};
      word_t     exp [4];
      word_t     a;
      word_t     b;
      a      = 32'h0000_1357;
      b      = 32'h0000_F0F1;
      exp[0] = a + b;
      exp[1] = a - b;   // Wraps below zero.
      exp[2] = a & b;
      exp[3] = a ^ b;
      start_test("ALU functions");
      load_start();
      emit(enc_li(5'd1, a[15:0]));
      emit(enc_li(5'd2, b[15:0]));
      for (int f = 0; f < 4; f++) emit(enc_alu(reg_idx_t'(5 + f), 5'd1, 5'd2, funcs[f]));
      for (int f = 0; f < 4; f++) emit(enc_li(reg_idx_t'(20 + f), 16'(64 + f)));
      for (int f = 0; f < 4; f++) emit(enc_store(reg_idx_t'(5 + f), reg_idx_t'(20 + f)));
      emit_self_jump();
      run_program(N_ALU);
      compare_count("store count", i_mem.log_count, 4);
      for (int f = 0; f < 4; f++) check_store(f, daddr_t'(64 + f), exp[f]);
      finish_test();
   endtask

   task automatic test_load_mem();
      start_test("load from memory");
      load_start();
      i_mem.write_data(20, 32'hCAFE_F00D);
      emit(enc_li(5'd1, 16'd20));
      emit(enc_li(5'd2, 16'd21));
      emit(enc_load(5'd3, 5'd1));
      emit(enc_store(5'd3, 5'd2));
      emit_self_jump();
      run_program(N_LOAD);
      compare_count("store count", i_mem.log_count, 1);
      check_store(0, 8'd21, 32'hCAFE_F00D);
      finish_test();
   endtask

   task automatic test_jump();
      start_test("jump over stores");
      load_start();
      emit(enc_li(5'd1, 16'h55AA));
      emit(enc_li(5'd2, 16'h0030));
      emit(enc_jump(8'd5));
      emit(enc_store(5'd2, 5'd1));   // Skipped.
      emit(enc_store(5'd2, 5'd1));   // Skipped.
      emit(enc_store(5'd1, 5'd2));
      emit_self_jump();
      run_program(N_JUMP);
      compare_count("store count", i_mem.log_count, 1);
      check_store(0, 8'h30, 32'h0000_55AA);
      compare_pc("PC after the self jump", imem_addr, pc_t'(prog_len - 1));
      finish_test();
   endtask

   task automatic test_random_ops();
      word_t a;
      word_t b;
      start_test("random ADD and XOR");
      for (int r = 0; r < RANDOM_RUNS; r++) begin
         a = $random(seed) & 32'h0000_FFFF;
         b = $random(seed) & 32'h0000_FFFF;
         load_start();
         emit(enc_li(5'd1, a[15:0]));
         emit(enc_li(5'd2, b[15:0]));
         emit(enc_alu(5'd3, 5'd1, 5'd2, ADD));
         emit(enc_alu(5'd4, 5'd1, 5'd2, XOR));
         emit(enc_li(5'd5, 16'h0080));
         emit(enc_li(5'd6, 16'h0081));
         emit(enc_store(5'd3, 5'd5));
         emit(enc_store(5'd4, 5'd6));
         emit_self_jump();
         run_program(N_RANDOM);
         compare_count("store count", i_mem.log_count, 2);
         check_store(0, 8'h80, a + b);
         check_store(1, 8'h81, a ^ b);
      end
      finish_test();
   endtask

   task automatic test_nop_opcodes();
      start_test("no-op and unused opcodes");
      load_start();
      emit(enc_li(5'd1, 16'h0BEE));
      emit(enc_li(5'd2, 16'h0010));
      emit(enc_raw(3'd0, 5'd1, 16'hFFFF));
      emit(enc_raw(3'd6, 5'd1, 16'hDEAD));
      emit(enc_raw(3'd7, 5'd1, 16'hBEEF));
      emit(enc_store(5'd1, 5'd2));
      emit_self_jump();
      run_program(N_NOP);
      compare_count("store count", i_mem.log_count, 1);
      check_store(0, 8'h10, 32'h0000_0BEE);
      finish_test();
   endtask

   initial begin
      arst_n      = 1'b0;
      cycle_count = 0;
      pass_count  = 0;
      fail_count  = 0;
      prog_len    = 0;
      seed        = 34370;
      i_mem.clear_log();
      i_mem.fill_memories();

      test_li_store();
      test_alu_funcs();
      test_load_mem();
      test_jump();
      test_random_ops();
      test_nop_opcodes();

      $display("Summary: %0d tests passed, %0d tests failed", pass_count, fail_count);
      if (fail_count == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

/* all.f */
+incdir+common
common/cpu_pkg.sv
rtl/alu.sv
rtl/regfile/register_file.sv
rtl/regfile/register_file_control.sv
rtl/stage_sequencer.sv
rtl/cpu_top.sv
bench/tb_memory_model.sv
bench/tb_cpu.sv
